// File: include/cpu_defines.svh
// global widths and sizes: data word, register count, data memory depth
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word width, shared by instructions, registers and data memory
`define DATA_W     16

// general purpose registers
// r0 is hardwired to zero, so 15 of these are writable
`define REG_CNT    16

// data memory words, addressed by the low bits of the alu result
`define DMEM_DEPTH 256

`endif

// File: rtl/cpu_pkg.sv
// core types: word and register address, opcode, alu op, condition and fetch state enums; control, flag and writeback structs
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`DATA_W-1:0]          word_t;     // one data or instruction word
	typedef logic [$clog2(`REG_CNT)-1:0] reg_addr_t; // register index

	// instr[15:12]
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b0001,
		NAND = 4'b0010,
		XOR  = 4'b0011,
		INC  = 4'b0100, // rd = rs + imm4
		SRA  = 4'b0101,
		SRL  = 4'b0110,
		SLL  = 4'b0111,
		LW   = 4'b1000,
		SW   = 4'b1001,
		LHB  = 4'b1010,
		LLB  = 4'b1011,
		B    = 4'b1100,
		CALL = 4'b1101, // no-op in this core
		RET  = 4'b1110, // no-op in this core
		ERR  = 4'b1111  // no-op, or HALT when all ones
	} opcode_e;

	// same encoding as the low three opcode bits
	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,
		ALU_SUB  = 3'b001,
		ALU_NAND = 3'b010,
		ALU_XOR  = 3'b011,
		ALU_INC  = 3'b100,
		ALU_SRA  = 3'b101,
		ALU_SRL  = 3'b110,
		ALU_SLL  = 3'b111
	} alu_op_e;

	// branch condition, instr[11:9]
	typedef enum logic [2:0] {
		EQ = 3'b000,
		LT = 3'b001,
		GT = 3'b010,
		OV = 3'b011,
		NE = 3'b100,
		GE = 3'b101,
		LE = 3'b110,
		TR = 3'b111 // always taken
	} cond_e;

	typedef enum logic [1:0] {
		FETCH  = 2'b00, // request out
		WAIT   = 2'b01, // waiting on instr_valid
		HALTED = 2'b10
	} fetch_state_e;

	typedef struct packed {
		logic    branch;
		logic    mem_to_reg;   // writeback from data memory
		alu_op_e alu_op;
		logic    alu_src;      // alu b from immediate
		logic    sign_ext_sel; // sign extend imm4
		logic    reg_rt_src;   // port b reads instr[11:8]
		logic    reg_write;
		logic    mem_write;
		logic    mem_read;
		logic    load_half;
		logic    half_spec;    // 0 LHB, 1 LLB
		logic    set_flags;    // ADD through SLL update z n v
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

// File: rtl/control_decoder.sv
// control_decoder: instruction word to control struct, halt detection
`timescale 1ns/100ps
`include "cpu_defines.svh"

module control_decoder import cpu_pkg::*; (
	input  logic [`DATA_W-1:0] instr,
	output ctrl_t              ctrl,
	output logic               halt
);

	opcode_e op;

	assign op   = opcode_e'(instr[15:12]);
	assign halt = &instr; // only 16'hFFFF stops, other ERR words fall through as no-ops

	always_comb begin
		ctrl = '0; // every field not named below stays low
		unique case (op)
			ADD, SUB, NAND, XOR, SRA, SRL, SLL: begin
				ctrl.alu_op    = alu_op_e'(op[2:0]); // alu function is the opcode low bits
				ctrl.reg_write = 1'b1;
				ctrl.set_flags = 1'b1;
			end
			INC: begin
				ctrl.alu_op    = ALU_INC;
				ctrl.alu_src   = 1'b1; // imm4, zero extended
				ctrl.reg_write = 1'b1;
				ctrl.set_flags = 1'b1;
			end
			LW: begin
				ctrl.mem_to_reg   = 1'b1;
				ctrl.alu_op       = ALU_ADD; // address = rs + offset
				ctrl.alu_src      = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.reg_write    = 1'b1;
				ctrl.mem_read     = 1'b1;
			end
			SW: begin
				ctrl.alu_op       = ALU_ADD;
				ctrl.alu_src      = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.reg_rt_src   = 1'b1; // store data comes from instr[11:8]
				ctrl.mem_write    = 1'b1;
			end
			LHB, LLB: begin
				// alu op is overridden by load_half, kept as opcode bits anyway
				ctrl.alu_op     = alu_op_e'(op[2:0]);
				ctrl.reg_rt_src = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.load_half  = 1'b1;
				ctrl.half_spec  = (op == LLB); // low byte replaced for LLB
			end
			B: begin
				ctrl.branch       = 1'b1;
				ctrl.sign_ext_sel = 1'b1; // offset is signed
			end
			CALL, RET, ERR: begin
				ctrl = '0; // no writeback, no store, pc just steps
			end
		endcase
	end

endmodule

// File: rtl/reg_file.sv
// reg_file: 16 x 16-bit registers, two async read ports, one clocked write port, r0 reads zero
`timescale 1ns/100ps
`include "cpu_defines.svh"

module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rd_addr_a,
	input  reg_addr_t rd_addr_b,
	output word_t     rd_data_a,
	output word_t     rd_data_b,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [`REG_CNT]; // entry 0 is never written

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin // r0 writes dropped
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the old value during a write cycle
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// File: rtl/alu.sv
// alu: add, sub, nand, xor, inc, shifts and half-byte load, with z n v flags
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
	input  alu_op_e    op,
	input  word_t      a,
	input  word_t      b,
	input  logic [7:0] imm8,
	input  logic       load_half,
	input  logic       half_spec,
	output word_t      result,
	output flags_t     flags
);

	localparam int MSB = `DATA_W - 1;

	word_t      sum;
	word_t      diff;
	word_t      fn_out; // function result before the half-load override
	logic [3:0] shamt;  // shifts use the low nibble of b
	logic       ovf;

	assign sum   = a + b;
	assign diff  = a - b;
	assign shamt = b[3:0];

	always_comb begin
		ovf = 1'b0; // only add, inc and sub can set it
		unique case (op)
			ALU_ADD, ALU_INC: begin
				fn_out = sum;
				ovf    = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]); // like signs, sign flipped
			end
			ALU_SUB: begin
				fn_out = diff;
				ovf    = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			ALU_NAND: fn_out = ~(a & b);
			ALU_XOR:  fn_out = a ^ b;
			ALU_SRA:  fn_out = word_t'($signed(a) >>> shamt); // sign fill
			ALU_SRL:  fn_out = a >> shamt;
			ALU_SLL:  fn_out = a << shamt;
		endcase
	end

	always_comb begin
		if (!load_half) begin
			result = fn_out;
		end else if (half_spec) begin
			result = {a[MSB:8], imm8}; // LLB keeps the high byte
		end else begin
			result = {imm8, a[7:0]}; // LHB keeps the low byte
		end
	end

	assign flags.z = (result == '0);
	assign flags.n = result[MSB];
	assign flags.v = ovf;

endmodule

// File: rtl/fetch_unit.sv
// fetch_unit: program counter, flag register, branch condition and fetch FSM
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       instr_valid,
	input  logic       accept,
	input  logic       halt,
	input  logic       branch,
	input  cond_e      cond,
	input  logic [8:0] offset,
	input  logic       set_flags,
	input  flags_t     new_flags,
	output logic       fetch_req,
	output word_t      fetch_addr,
	output logic       instr_ready,
	output logic       halted
);

	fetch_state_e state;
	word_t        pc;
	word_t        pc_inc;
	word_t        target;
	flags_t       flags_q; // flags left by the last flag-setting op
	logic         taken;

	assign pc_inc = pc + 1'b1;
	assign target = pc_inc + {{(`DATA_W-9){offset[8]}}, offset}; // pc+1+offset

	// condition on the stored flags, never on this instruction's result
	always_comb begin
		unique case (cond)
			EQ: taken = flags_q.z;
			LT: taken = flags_q.n;
			GT: taken = !flags_q.z && !flags_q.n;
			OV: taken = flags_q.v;
			NE: taken = !flags_q.z;
			GE: taken = !flags_q.n;
			LE: taken = flags_q.n || flags_q.z;
			TR: taken = 1'b1;
		endcase
	end

	// fetch_req is a flop so it stays low through reset, and FETCH waits one extra cycle for it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= FETCH;
			fetch_req <= 1'b0;
		end else begin
			unique case (state)
				FETCH: begin
					if (fetch_req) begin
						state <= WAIT; // request was out this cycle
					end
					fetch_req <= !fetch_req;
				end
				WAIT: begin
					if (instr_valid) begin // ready is high all through WAIT
						state     <= halt ? HALTED : FETCH;
						fetch_req <= !halt;
					end
				end
				HALTED: begin
					state <= HALTED; // only reset leaves
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			flags_q <= '0;
		end else if (accept) begin
			pc <= (branch && taken) ? target : pc_inc;
			if (set_flags) begin
				flags_q <= new_flags;
			end
		end
	end

	assign fetch_addr  = pc; // stable until the accept edge
	assign instr_ready = (state == WAIT);
	assign halted      = (state == HALTED);

endmodule

// File: rtl/data_mem.sv
// data_mem: 256-word data memory, async read, write on the clock edge
`timescale 1ns/100ps
`include "cpu_defines.svh"

module data_mem import cpu_pkg::*; (
	input  logic  clk,
	input  logic  wr_en,
	input  word_t addr,
	input  word_t wr_data,
	output word_t rd_data
);

	localparam int AW = $clog2(`DMEM_DEPTH);

	word_t         mem [`DMEM_DEPTH]; // contents undefined until written
	logic [AW-1:0] idx;

	assign idx = addr[AW-1:0]; // upper address bits ignored, addresses wrap

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[idx] <= wr_data;
		end
	end

	assign rd_data = mem[idx];

endmodule

// File: rtl/cpu_core.sv
// cpu_core: top level with decoder, register file, alu, fetch unit, data memory and writeback trace
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_core import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	output logic  fetch_req,
	output word_t fetch_addr,
	input  logic  instr_valid,
	output logic  instr_ready,
	input  word_t instr,
	output logic  wb_valid,
	output wb_t   wb,
	output logic  halted
);

	ctrl_t     ctrl;
	logic      halt;
	logic      accept;    // instruction taken and executed this edge
	reg_addr_t rd_addr;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	reg_addr_t addr_a;
	reg_addr_t addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	word_t     imm;
	word_t     alu_b;
	word_t     alu_result;
	flags_t    alu_flags;
	word_t     dmem_rd_data;
	word_t     wb_data;
	logic      reg_wr_en;

	assign accept  = instr_valid && instr_ready;
	assign rd_addr = instr[11:8];
	assign rs_addr = instr[7:4];
	assign rt_addr = instr[3:0];

	// half loads read rd itself, the kept byte comes from it
	assign addr_a = ctrl.load_half ? rd_addr : rs_addr;
	assign addr_b = ctrl.reg_rt_src ? rd_addr : rt_addr; // SW data register

	assign imm = ctrl.sign_ext_sel ? {{(`DATA_W-4){instr[3]}}, instr[3:0]}
	                               : {{(`DATA_W-4){1'b0}}, instr[3:0]};
	assign alu_b = ctrl.alu_src ? imm : rd_data_b;

	assign wb_data   = (ctrl.mem_to_reg && ctrl.mem_read) ? dmem_rd_data : alu_result;
	assign reg_wr_en = accept && ctrl.reg_write; // nothing changes without a handshake

	control_decoder u_dec (
		.instr (instr),
		.ctrl  (ctrl),
		.halt  (halt)
	);

	reg_file u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (addr_a),
		.rd_addr_b (addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (reg_wr_en),
		.wr_addr   (rd_addr),
		.wr_data   (wb_data)
	);

	alu u_alu (
		.op        (ctrl.alu_op),
		.a         (rd_data_a),
		.b         (alu_b),
		.imm8      (instr[7:0]),
		.load_half (ctrl.load_half),
		.half_spec (ctrl.half_spec),
		.result    (alu_result),
		.flags     (alu_flags)
	);

	fetch_unit u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.accept      (accept),
		.halt        (halt),
		.branch      (ctrl.branch),
		.cond        (cond_e'(instr[11:9])),
		.offset      (instr[8:0]),
		.set_flags   (ctrl.set_flags),
		.new_flags   (alu_flags),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.instr_ready (instr_ready),
		.halted      (halted)
	);

	data_mem u_dmem (
		.clk     (clk),
		.wr_en   (accept && ctrl.mem_write),
		.addr    (alu_result), // rs + sign-extended offset
		.wr_data (rd_data_b),
		.rd_data (dmem_rd_data)
	);

	// trace pulse in the cycle after the accepting edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= reg_wr_en && (rd_addr != '0); // r0 writes leave no trace
		end
	end

	always_ff @(posedge clk) begin
		if (reg_wr_en) begin
			wb <= '{rd: rd_addr, data: wb_data};
		end
	end

endmodule

// File: testbench/cpu_core_checker.sv
// cpu_core_checker: concurrent assertions on fetch handshake, halt behaviour and trace port, bound to cpu_core
`timescale 1ns/100ps

module cpu_core_checker import cpu_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  fetch_req,
	input word_t fetch_addr,
	input logic  instr_valid,
	input logic  instr_ready,
	input logic  wb_valid,
	input wb_t   wb,
	input logic  halted
);

	// memory answers only while the core sits in WAIT
	valid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> instr_ready)
		else $error("instr_valid high outside WAIT");

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_ready && !instr_valid) |=> $stable(fetch_addr)) // held until accept
		else $error("fetch_addr moved while waiting for the response");

	// nothing leaves the core once it has stopped
	halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> (!fetch_req && !wb_valid))
		else $error("fetch_req or wb_valid after halt");

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted dropped without reset");

	no_r0_trace: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb.rd != '0)) // r0 writes are dropped silently
		else $error("trace entry for r0");

endmodule

bind cpu_core cpu_core_checker u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.fetch_req   (fetch_req),
	.fetch_addr  (fetch_addr),
	.instr_valid (instr_valid),
	.instr_ready (instr_ready),
	.wb_valid    (wb_valid),
	.wb          (wb),
	.halted      (halted)
);

// File: testbench/cpu_core_tb.sv
// cpu_core_tb: clock and reset, instruction memory model, program table and expected trace table
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_core_tb import cpu_pkg::*; ();

	localparam int PROG_LEN     = 47;
	localparam int TRACE_LEN    = 19;
	localparam int WAIT_LIMIT   = 100; // cycles allowed for any single wait
	localparam int QUIET_CYCLES = 20;  // window watched after halt

	// program words by address, sections noted per row
	localparam word_t PROGRAM [PROG_LEN] = '{
		16'hB134, 16'hA112, 16'hA280, 16'hB2F0,           // 0-3 r1 by LLB then LHB, r2 by LHB then LLB
		16'h4305, 16'h0412, 16'h1512, 16'h2612, 16'h3712, // 4-8 INC ADD SUB NAND XOR
		16'h5823, 16'h6923, 16'h7A13,                     // 9-11 shifts by r3
		16'hBB40, 16'h94BE, 16'h8CBE,                     // 12-14 SW then LW at r11-2
		16'h1D11, 16'hC001, 16'h4E01, 16'hC801, 16'hC401, // 15-19 z set, EQ taken
		16'hCC01, 16'h4E03, 16'h0D22, 16'hC601, 16'h4E04, // 20-24 v set by ADD
		16'hC401, 16'h4E05, 16'hCA01, 16'h4E06, 16'h3D12, // 25-29 n set by XOR
		16'hC201, 16'h4E07, 16'hC601, 16'hCA01, 16'hC001, // 30-34 LT taken, rest fall
		16'h4E08, 16'h0012, 16'hD123, 16'hCE02, 16'h4E09, // 35-39 r0 write, CALL
		16'h4E0A, 16'hCE02, 16'h4F0A, 16'hCE02, 16'hCFFD, // 40-44 back branch -3
		16'h4E0B, 16'hFFFF                                // 45-46 HALT
	};

	// rd and data of every register write, in order
	localparam wb_t EXPECTED [TRACE_LEN] = '{
		{4'd1, 16'h0034}, {4'd1, 16'h1234}, {4'd2, 16'h8000}, {4'd2, 16'h80F0},
		{4'd3, 16'h0005}, {4'd4, 16'h9324}, {4'd5, 16'h9144}, {4'd6, 16'hFFCF},
		{4'd7, 16'h92C4}, {4'd8, 16'hFC07}, {4'd9, 16'h0407}, {4'd10, 16'h4680},
		{4'd11, 16'h0040}, {4'd12, 16'h9324},
		{4'd13, 16'h0000}, {4'd13, 16'h01E0}, {4'd13, 16'h92C4}, {4'd14, 16'h0008},
		{4'd15, 16'h000A}
	};

	logic  clk;
	logic  rst_n;
	logic  fetch_req;
	word_t fetch_addr;
	logic  instr_valid = 1'b0;
	logic  instr_ready;
	word_t instr = '0;
	logic  wb_valid;
	wb_t   wb;
	logic  halted;
	logic  req_pending = 1'b0; // request seen, response still delayed
	int    delay_left = 0;
	int    trace_cnt = 0;

	cpu_core dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb          (wb),
		.halted      (halted)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [15:0] expected,
	                          input logic [15:0] actual);
		assert (actual === expected)
			else abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
	endtask

	// samples right after each rising edge, so values are the settled pre-edge ones
	task automatic wait_trace(input int idx);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!wb_valid && cycles < WAIT_LIMIT);
		assert (wb_valid)
			else abort_run($sformatf("no trace entry %0d within %0d cycles", idx, WAIT_LIMIT));
	endtask

	task automatic wait_halted();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!halted && cycles < WAIT_LIMIT);
		assert (halted) else abort_run("core did not halt after the last trace entry");
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// instruction memory, one response per request after 0 to 3 cycles
	always @(posedge clk) begin : imem_model
		int delay;
		delay = 0;
		if (!rst_n) begin
			req_pending <= 1'b0;
		end else if (instr_valid) begin
			if (instr_ready) begin
				instr_valid <= 1'b0; // accepted at this edge
			end
		end else if (fetch_req || req_pending) begin
			delay = fetch_req ? $urandom_range(3, 0) : delay_left;
			if (delay == 0) begin
				assert (fetch_addr < PROG_LEN) else abort_run("fetch beyond the end of the program");
				instr       <= PROGRAM[fetch_addr];
				instr_valid <= 1'b1;
				req_pending <= 1'b0;
			end else begin
				delay_left  <= delay - 1;
				req_pending <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && wb_valid) begin
			trace_cnt <= trace_cnt + 1;
		end
	end

	initial begin : main
		void'($urandom(1));
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		assert (!fetch_req && !instr_ready && !wb_valid && !halted)
			else abort_run("core outputs active during reset");
		rst_n <= 1'b1;
		for (int i = 0; i < TRACE_LEN; i++) begin
			wait_trace(i);
			check_word($sformatf("wb.rd[%0d]", i), 16'(EXPECTED[i].rd), 16'(wb.rd));
			check_word($sformatf("wb.data[%0d]", i), EXPECTED[i].data, wb.data);
		end
		wait_halted();
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			assert (!fetch_req && !wb_valid) else abort_run("fetch or trace activity after halt");
		end
		check_word("trace_cnt", 16'(TRACE_LEN), 16'(trace_cnt));
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: cpu_core.f
+incdir+include
rtl/cpu_pkg.sv
rtl/control_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/fetch_unit.sv
rtl/data_mem.sv
rtl/cpu_core.sv
testbench/cpu_core_checker.sv
testbench/cpu_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb -Mdir obj_dir -f cpu_core.f
	./obj_dir/Vcpu_core_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
